// File: design/rsa_arith_pkg.sv
package rsa_arith_pkg;

	// operand width, one RSA key
	localparam int KEY_W = 256;

	// bit and step counters, must reach KEY_W
	localparam int CNT_W = 9;

	// radix-2 steps in one Montgomery product
	// one step per bit of the first operand
	localparam logic [CNT_W-1:0] MONT_ITER = CNT_W'(KEY_W);

	// plain operand, modulus or result
	typedef logic [KEY_W-1:0] word_t;

	// two spare bits on top of a word
	// a Montgomery step adds b and n to a value below 2n, so it peaks below 4n
	typedef logic [KEY_W+1:0] acc_t;

endpackage

// File: design/rsa_ctrl_pkg.sv
package rsa_ctrl_pkg;

	// exponent sequencer states
	typedef enum logic [2:0] {
		IDLE, // waiting for a start
		PREP, // cipher text moving into the Montgomery domain
		LOAD, // start pulse to both multipliers
		MULT, // multipliers busy
		NEXT  // take the products, step to the next bit
	} core_state_e;

	// montgomery_mul: load, MONT_ITER steps, conditional subtract
	localparam logic [rsa_arith_pkg::CNT_W-1:0] MONT_LAT = rsa_arith_pkg::MONT_ITER + 2'd2;

	// modulo_product: load, one doubling per key bit, output
	// the doubling count equals the key width, same as MONT_ITER
	localparam logic [rsa_arith_pkg::CNT_W-1:0] PREP_LAT = rsa_arith_pkg::MONT_ITER + 2'd2;

endpackage

// File: design/mont_if.sv
// one Montgomery multiplier seen from the sequencer
// a and b held stable in the start cycle
// res valid from done until the next start
interface mont_if;

	logic start;                // one-cycle pulse
	rsa_arith_pkg::word_t a;    // multiplier operand, scanned bit by bit
	rsa_arith_pkg::word_t b;    // multiplicand, below n
	rsa_arith_pkg::word_t res;  // a * b * R^-1 mod n
	logic done;                 // one-cycle pulse

	// sequencer side
	modport ctrl (
		output start,
		output a,
		output b,
		input  res,
		input  done
	);

	// multiplier side
	modport unit (
		input  start,
		input  a,
		input  b,
		output res,
		output done
	);

endinterface

// File: design/modulo_product.sv
// a * 2^KEY_W mod n by repeated doubling
// a must be below n, n odd and above 1
module modulo_product (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  rsa_arith_pkg::word_t i_a,
	input  rsa_arith_pkg::word_t i_n,
	output rsa_arith_pkg::word_t o_t,
	output logic                 o_done
);

	logic busy;
	logic [rsa_arith_pkg::CNT_W-1:0] step_cnt;
	logic last_step;

	rsa_arith_pkg::word_t t_r; // running value, kept below n
	rsa_arith_pkg::word_t n_r;
	rsa_arith_pkg::acc_t t_dbl;
	rsa_arith_pkg::acc_t t_next;

	// all doublings done, this cycle writes the output
	assign last_step = (step_cnt == rsa_ctrl_pkg::PREP_LAT - 2'd2);

	always_comb begin
		t_dbl = {1'b0, t_r, 1'b0}; // 2t < 2n, fits
		if (t_dbl >= {2'b00, n_r}) begin
			t_next = t_dbl - {2'b00, n_r};
		end else begin
			t_next = t_dbl;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy     <= 1'b0;
			step_cnt <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (!busy) begin
				if (i_start) begin
					busy     <= 1'b1;
					step_cnt <= '0;
				end
			end else if (last_step) begin
				busy   <= 1'b0;
				o_done <= 1'b1;
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	// operands and running value
	always_ff @(posedge i_clk) begin
		if (!busy && i_start) begin
			t_r <= i_a;
			n_r <= i_n;
		end else if (busy && !last_step) begin
			t_r <= t_next[rsa_arith_pkg::KEY_W-1:0];
		end
		if (busy && last_step) begin
			o_t <= t_r; // held until the next run ends
		end
	end

endmodule

// File: design/montgomery_mul.sv
// radix-2 Montgomery product, res = a * b * 2^-KEY_W mod n
// b below n, n odd, so the result lands below n
module montgomery_mul (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  rsa_arith_pkg::word_t i_n,
	mont_if.unit                 bus
);

	logic busy;
	logic [rsa_arith_pkg::CNT_W-1:0] step_cnt;
	logic last_step;

	rsa_arith_pkg::word_t a_r; // shifts right, bit 0 is the current bit
	rsa_arith_pkg::word_t b_r;
	rsa_arith_pkg::acc_t acc_r; // stays below 2n between steps
	rsa_arith_pkg::acc_t sum_add;
	rsa_arith_pkg::acc_t sum_red;
	rsa_arith_pkg::acc_t acc_sub;
	rsa_arith_pkg::acc_t n_ext;

	assign n_ext = {2'b00, i_n};
	assign last_step = (step_cnt == rsa_ctrl_pkg::MONT_LAT - 2'd2);

	always_comb begin
		// add b when the operand bit is set
		if (a_r[0]) begin
			sum_add = acc_r + {2'b00, b_r};
		end else begin
			sum_add = acc_r;
		end
		// add n when odd so the halving is exact
		if (sum_add[0]) begin
			sum_red = sum_add + n_ext;
		end else begin
			sum_red = sum_add;
		end
		acc_sub = acc_r - n_ext; // only used when acc_r >= n
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy     <= 1'b0;
			step_cnt <= '0;
			bus.done <= 1'b0;
		end else begin
			bus.done <= 1'b0;
			if (!busy) begin
				if (bus.start) begin
					busy     <= 1'b1;
					step_cnt <= '0;
				end
			end else if (last_step) begin
				busy     <= 1'b0;
				bus.done <= 1'b1;
			end else begin
				step_cnt <= step_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!busy && bus.start) begin
			a_r   <= bus.a;
			b_r   <= bus.b;
			acc_r <= '0;
		end else if (busy && !last_step) begin
			acc_r <= sum_red >> 1;
			a_r   <= a_r >> 1;
		end
		// final reduction into [0, n)
		if (busy && last_step) begin
			if (acc_r >= n_ext) begin
				bus.res <= acc_sub[rsa_arith_pkg::KEY_W-1:0];
			end else begin
				bus.res <= acc_r[rsa_arith_pkg::KEY_W-1:0];
			end
		end
	end

endmodule

// File: design/rsa_core.sv
// exponent sequencer, d scanned from LSB to MSB
// power squares every bit, result picks it up on the one bits
module rsa_core (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  rsa_arith_pkg::word_t i_d,
	input  rsa_arith_pkg::word_t i_t,      // a * R mod n from prep
	input  logic                 i_t_done,
	mont_if.ctrl                 sq,
	mont_if.ctrl                 mul,
	output rsa_arith_pkg::word_t o_a_pow_d,
	output logic                 o_finished
);

	rsa_ctrl_pkg::core_state_e state;

	logic [rsa_arith_pkg::CNT_W-1:0] bit_cnt;
	logic last_bit;
	logic mult_done;

	rsa_arith_pkg::word_t d_r;   // shifted right once per bit
	rsa_arith_pkg::word_t pow_r; // a^(2^i) * R mod n
	rsa_arith_pkg::word_t res_r; // partial result, plain domain
	rsa_arith_pkg::word_t res_next;

	assign last_bit = (bit_cnt == rsa_arith_pkg::MONT_ITER - 1'b1);

	// both units share a latency, the mul check only matters on one bits
	assign mult_done = sq.done && (mul.done || !d_r[0]);

	// result after this bit
	assign res_next = d_r[0] ? mul.res : res_r;

	// square the power every bit
	assign sq.start = (state == rsa_ctrl_pkg::LOAD);
	assign sq.a     = pow_r;
	assign sq.b     = pow_r;

	// multiply only when the exponent bit is one
	assign mul.start = (state == rsa_ctrl_pkg::LOAD) && d_r[0];
	assign mul.a     = res_r;
	assign mul.b     = pow_r;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state      <= rsa_ctrl_pkg::IDLE;
			bit_cnt    <= '0;
			o_finished <= 1'b0;
			o_a_pow_d  <= '0;
		end else begin
			o_finished <= 1'b0;
			case (state)
				rsa_ctrl_pkg::IDLE: begin
					if (i_start) begin
						state <= rsa_ctrl_pkg::PREP;
					end
				end
				rsa_ctrl_pkg::PREP: begin
					if (i_t_done) begin
						state   <= rsa_ctrl_pkg::LOAD;
						bit_cnt <= '0;
					end
				end
				rsa_ctrl_pkg::LOAD: begin
					state <= rsa_ctrl_pkg::MULT;
				end
				rsa_ctrl_pkg::MULT: begin
					if (mult_done) begin
						state <= rsa_ctrl_pkg::NEXT;
					end
				end
				rsa_ctrl_pkg::NEXT: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (last_bit) begin
						state      <= rsa_ctrl_pkg::IDLE;
						o_finished <= 1'b1;
						o_a_pow_d  <= res_next; // already plain, no conversion
					end else begin
						state <= rsa_ctrl_pkg::LOAD;
					end
				end
				default: begin
					state <= rsa_ctrl_pkg::IDLE;
				end
			endcase
		end
	end

	// exponent, power and result registers
	always_ff @(posedge i_clk) begin
		if (state == rsa_ctrl_pkg::IDLE && i_start) begin
			d_r <= i_d;
		end
		if (state == rsa_ctrl_pkg::PREP && i_t_done) begin
			pow_r <= i_t;
			// plain 1, each product then strips one R
			res_r <= {{(rsa_arith_pkg::KEY_W-1){1'b0}}, 1'b1};
		end
		if (state == rsa_ctrl_pkg::NEXT) begin
			pow_r <= sq.res;
			res_r <= res_next;
			d_r   <= d_r >> 1;
		end
	end

endmodule

// File: design/rsa_top.sv
module rsa_top (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  rsa_arith_pkg::word_t i_a, // cipher text
	input  rsa_arith_pkg::word_t i_d, // private exponent
	input  rsa_arith_pkg::word_t i_n, // odd modulus
	output rsa_arith_pkg::word_t o_a_pow_d,
	output logic                 o_finished
);

	mont_if sq_bus ();
	mont_if mul_bus ();

	rsa_arith_pkg::word_t t_val;
	logic t_done;

	logic run_r;
	logic start_ok;
	rsa_arith_pkg::word_t n_r;

	// accepted only while idle, the finish cycle counts as idle
	assign start_ok = i_start && (!run_r || o_finished);

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			run_r <= 1'b0;
		end else if (start_ok) begin
			run_r <= 1'b1;
		end else if (o_finished) begin
			run_r <= 1'b0;
		end
	end

	// modulus held for the whole run
	always_ff @(posedge i_clk) begin
		if (start_ok) begin
			n_r <= i_n;
		end
	end

	modulo_product prep0 (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_start (start_ok),
		.i_a     (i_a),
		.i_n     (i_n),
		.o_t     (t_val),
		.o_done  (t_done)
	);

	rsa_core core0 (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_start    (start_ok),
		.i_d        (i_d),
		.i_t        (t_val),
		.i_t_done   (t_done),
		.sq         (sq_bus.ctrl),
		.mul        (mul_bus.ctrl),
		.o_a_pow_d  (o_a_pow_d),
		.o_finished (o_finished)
	);

	montgomery_mul sq0 (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_n   (n_r),
		.bus   (sq_bus.unit)
	);

	montgomery_mul mul0 (
		.i_clk (i_clk),
		.i_rst (i_rst),
		.i_n   (n_r),
		.bus   (mul_bus.unit)
	);

endmodule

// File: verif/tb_rsa.sv
module tb_rsa;

	localparam int KEY_W = rsa_arith_pkg::KEY_W;

	// one run is 66,819 cycles, rounded up
	localparam int RUN_CYCLES = 70_000;
	localparam int NUM_RUNS = 8;
	localparam int MAX_CYCLES = (NUM_RUNS + 2) * RUN_CYCLES; // two runs of margin

	logic clk;
	logic rst;
	logic start;
	rsa_arith_pkg::word_t a_val;
	rsa_arith_pkg::word_t d_val;
	rsa_arith_pkg::word_t n_val;
	rsa_arith_pkg::word_t a_pow_d;
	logic finished;

	integer seed;
	int cycle_cnt;
	int errors;
	int fin_cnt;   // finish pulses seen so far
	int pass_cnt;
	int fail_cnt;
	logic fin_prev;
	rsa_arith_pkg::word_t held_val;

	rsa_top dut0 (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_start    (start),
		.i_a        (a_val),
		.i_d        (d_val),
		.i_n        (n_val),
		.o_a_pow_d  (a_pow_d),
		.o_finished (finished)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout reached after %0d cycles, the DUT did not finish", cycle_cnt);
			$display("Test failed");
			$finish;
		end
	end

	// finish pulse width and output hold, checked every cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (finished) begin
				fin_cnt++;
				held_val = a_pow_d;
				assert (!fin_prev) else begin
					$display("o_finished stayed high for more than one cycle");
					errors++;
				end
			end else if (fin_cnt == 0) begin
				assert (a_pow_d == '0) else begin
					$display("FAIL o_a_pow_d before first run: expected %h got %h",
						rsa_arith_pkg::word_t'(0), a_pow_d);
					errors++;
				end
			end else begin
				assert (a_pow_d == held_val) else begin
					$display("FAIL o_a_pow_d between runs: expected %h got %h", held_val,
						a_pow_d);
					errors++;
				end
			end
			fin_prev = finished;
		end
	end

	// 256-bit word from eight draws
	task automatic rand_word(output rsa_arith_pkg::word_t w);
		int k;
		w = '0;
		for (k = 0; k < 8; k++) begin
			w = {w[KEY_W-33:0], 32'($random(seed))};
		end
	endtask

	// odd modulus with the top bit set, base below it
	task automatic rand_operands(output rsa_arith_pkg::word_t base,
			output rsa_arith_pkg::word_t modn);
		rand_word(modn);
		modn[KEY_W-1] = 1'b1;
		modn[0] = 1'b1;
		rand_word(base);
		base = base % modn;
	endtask

	// plain square-and-multiply on double-width products
	task automatic ref_mod_exp(input rsa_arith_pkg::word_t base,
			input rsa_arith_pkg::word_t expo, input rsa_arith_pkg::word_t modn,
			output rsa_arith_pkg::word_t result);
		logic [2*KEY_W-1:0] wide_n;
		logic [2*KEY_W-1:0] acc;
		logic [2*KEY_W-1:0] pw;
		int i;
		wide_n = {{KEY_W{1'b0}}, modn};
		acc = (2*KEY_W)'(1) % wide_n;
		pw = {{KEY_W{1'b0}}, base} % wide_n;
		for (i = 0; i < KEY_W; i++) begin
			if (expo[i]) begin
				acc = (acc * pw) % wide_n;
			end
			pw = (pw * pw) % wide_n;
		end
		result = acc[KEY_W-1:0];
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			pass_cnt++;
			$display("[%s] ok", name);
		end else begin
			fail_cnt++;
			$display("[%s] failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// one exponentiation, optionally with a stray start mid-run
	task automatic run_case(input string name, input rsa_arith_pkg::word_t base,
			input rsa_arith_pkg::word_t expo, input rsa_arith_pkg::word_t modn,
			input bit with_restart);
		rsa_arith_pkg::word_t expected;
		rsa_arith_pkg::word_t junk;
		int errors_before;
		int fin_before;
		errors_before = errors;
		fin_before = fin_cnt;
		ref_mod_exp(base, expo, modn, expected);
		@(negedge clk);
		a_val = base;
		d_val = expo;
		n_val = modn;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (with_restart) begin
			repeat (100) @(negedge clk);
			rand_operands(junk, n_val); // new operands, inputs left changed
			a_val = junk;
			rand_word(junk);
			d_val = junk;
			start = 1'b1;
			@(negedge clk);
			start = 1'b0;
		end
		while (!finished) begin
			@(negedge clk);
		end
		assert (a_pow_d == expected) else begin
			$display("FAIL o_a_pow_d: expected %h got %h", expected, a_pow_d);
			errors++;
		end
		@(posedge clk); // the monitor counted the pulse at the negedge before
		assert (fin_cnt == fin_before + 1) else begin
			$display("expected one finish pulse for the run but saw %0d", fin_cnt - fin_before);
			errors++;
		end
		report_test(name, errors_before);
	endtask

	initial begin
		rsa_arith_pkg::word_t base;
		rsa_arith_pkg::word_t modn;
		rsa_arith_pkg::word_t expo;
		int errors_before;
		int r;
		seed = 32'hdfb0_9abd;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		a_val = '0;
		d_val = '0;
		n_val = '0;
		cycle_cnt = 0;
		errors = 0;
		fin_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		fin_prev = 1'b0;
		held_val = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		errors_before = errors;
		@(negedge clk);
		assert (!finished) else begin
			$display("FAIL o_finished after reset: expected %h got %h", 1'b0, finished);
			errors++;
		end
		assert (a_pow_d == '0) else begin
			$display("FAIL o_a_pow_d after reset: expected %h got %h",
				rsa_arith_pkg::word_t'(0), a_pow_d);
			errors++;
		end
		report_test("reset", errors_before);

		rand_operands(base, modn);
		run_case("d_zero", base, '0, modn, 1'b0);
		rand_operands(base, modn);
		run_case("d_one", base, rsa_arith_pkg::word_t'(1), modn, 1'b0);

		// stray start while busy, not the last run so a wrong accept shows up later
		rand_operands(base, modn);
		rand_word(expo);
		run_case("start_ignored", base, expo, modn, 1'b1);

		for (r = 0; r < 5; r++) begin
			rand_operands(base, modn);
			rand_word(expo);
			run_case($sformatf("random_%0d", r), base, expo, modn, 1'b0);
		end

		$display("tests run %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt,
			fail_cnt);
		if (fail_cnt == 0 && errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: sources.f
design/rsa_arith_pkg.sv
design/rsa_ctrl_pkg.sv
design/mont_if.sv
design/modulo_product.sv
design/montgomery_mul.sv
design/rsa_core.sv
design/rsa_top.sv
verif/tb_rsa.sv

// File: run.sh
#!/bin/sh
# build and run the RSA core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_rsa -f sources.f

./obj_dir/Vtb_rsa | tee sim.log

if grep -q "Test passed" sim.log; then
	exit 0
else
	exit 1
fi
